/* mpt_pkg.sv */
// Shared widths, enums, request and response structs
// Table entry views and the packed union decoding one memory word
// PLB refill record and walk result

package mpt_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Supervisor physical address
    localparam int unsigned SPA_WIDTH         = 32;
    localparam int unsigned PAGE_OFFSET_WIDTH = 12;
    // Index bits taken from the address per level
    localparam int unsigned LEVEL_IDX_WIDTH   = 10;
    localparam int unsigned PPN_WIDTH         = 20;
    localparam int unsigned SDID_WIDTH        = 8;
    // Table entry and memory data
    localparam int unsigned MPTE_WIDTH        = 32;
    // Fixed by the entry formats below
    localparam int unsigned NUM_LEVELS        = 2;

    // Reserved fields fill whatever the entry views leave over
    localparam int unsigned PTR_RSVD_WIDTH  = MPTE_WIDTH - 2 - PPN_WIDTH;
    localparam int unsigned LEAF_RSVD_WIDTH = MPTE_WIDTH - 2 - 3;

    //////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        READ    = 2'd0,
        WRITE   = 2'd1,
        EXECUTE = 2'd2
    } mpt_access_e;

    typedef enum logic [1:0] {
        NO_ERROR        = 2'd0,
        ENTRY_NOT_VALID = 2'd1,
        RESERVED_SET    = 2'd2,
        LEAF_MISSING    = 2'd3
    } page_format_fault_e;

    //////////////////////////////////////////////////
    // Request and response
    //////////////////////////////////////////////////

    // Domain and table root, as held in the CSR
    typedef struct packed {
        logic [SDID_WIDTH-1:0] sdid;
        logic [PPN_WIDTH-1:0]  ppn;
    } mmpt_reg_t;

    typedef struct packed {
        logic [SPA_WIDTH-1:0] spa;
        mmpt_reg_t            mmpt;
        mpt_access_e          access_type;
    } mptw_req_t;

    typedef struct packed {
        logic               access_fault;
        page_format_fault_e format_error;
    } mptw_rsp_t;

    typedef struct packed {
        logic r;
        logic w;
        logic x;
    } mpt_perm_t;

    //////////////////////////////////////////////////
    // Table entry
    //////////////////////////////////////////////////

    // Non-leaf view, leaf bit is 0
    typedef struct packed {
        logic                      valid;
        logic                      leaf;
        logic [PTR_RSVD_WIDTH-1:0] reserved;
        logic [PPN_WIDTH-1:0]      ppn;
    } mpte_ptr_t;

    // Leaf view, leaf bit is 1
    typedef struct packed {
        logic                       valid;
        logic                       leaf;
        mpt_perm_t                  perm;
        logic [LEAF_RSVD_WIDTH-1:0] reserved;
    } mpte_leaf_t;

    // Valid and leaf sit at the same place in both views
    typedef union packed {
        mpte_ptr_t  ptr;
        mpte_leaf_t leaf;
    } mpte_u;

    //////////////////////////////////////////////////
    // Internal records
    //////////////////////////////////////////////////

    typedef struct packed {
        mpt_perm_t          perm;
        page_format_fault_e format_error;
    } walk_result_t;

    // Tag is sdid plus page number
    typedef struct packed {
        logic [SDID_WIDTH-1:0] sdid;
        logic [PPN_WIDTH-1:0]  vpn;
        mpt_perm_t             perm;
    } plb_fill_t;

endpackage : mpt_pkg

/* plb_cache.sv */
// Fully associative protection lookaside buffer
// Registered tag compare, round-robin refill, flush of all entries

`timescale 1ns/1ps

module plb_cache #(
    parameter int unsigned PLB_ENTRIES = 4
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               flush_i,

    // Lookup from the merger
    input  logic               lookup_start_i,
    input  mpt_pkg::mptw_req_t lookup_req_i,
    output logic               plb_hit_o,
    output mpt_pkg::mpt_perm_t plb_perm_o,

    // Refill after a clean walk
    input  logic               fill_valid_i,
    input  mpt_pkg::plb_fill_t fill_i
);

    // Pointer stays one bit wide for a single entry
    localparam int unsigned PTR_WIDTH = (PLB_ENTRIES > 1) ? $clog2(PLB_ENTRIES) : 1;
    localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(PLB_ENTRIES - 1);

    logic [PLB_ENTRIES-1:0]  valid_q;
    mpt_pkg::plb_fill_t      entry_q [PLB_ENTRIES];
    logic [PTR_WIDTH-1:0]    rr_ptr_q;

    logic [mpt_pkg::PPN_WIDTH-1:0] lookup_vpn;
    logic                          lookup_hit;
    mpt_pkg::mpt_perm_t            lookup_perm;

    //////////////////////////////////////////////////
    // Tag compare
    //////////////////////////////////////////////////

    assign lookup_vpn = lookup_req_i.spa[mpt_pkg::SPA_WIDTH-1:mpt_pkg::PAGE_OFFSET_WIDTH];

    // First matching entry wins, refill only follows a miss
    always_comb begin
        lookup_hit  = 1'b0;
        lookup_perm = '0;
        for (int i = 0; i < PLB_ENTRIES; i++) begin
            if (!lookup_hit && valid_q[i] &&
                entry_q[i].sdid == lookup_req_i.mmpt.sdid &&
                entry_q[i].vpn == lookup_vpn) begin
                lookup_hit  = 1'b1;
                lookup_perm = entry_q[i].perm;
            end
        end
    end

    // Result one cycle after lookup_start
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            plb_hit_o <= 1'b0;
        end else begin
            plb_hit_o <= lookup_start_i && lookup_hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_start_i) begin
            plb_perm_o <= lookup_perm;
        end
    end

    //////////////////////////////////////////////////
    // Refill and flush
    //////////////////////////////////////////////////

    // Flush beats a fill in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (flush_i) begin
            valid_q  <= '0;
        end else if (fill_valid_i) begin
            valid_q[rr_ptr_q] <= 1'b1;
            // Wrap at the last entry
            rr_ptr_q <= (rr_ptr_q == LAST_PTR) ? '0 : rr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_valid_i && !flush_i) begin
            entry_q[rr_ptr_q] <= fill_i;
        end
    end

endmodule : plb_cache

/* mpt_table_walker.sv */
// Two-level memory protection table walker
// One four-phase read per level, entry decode and format checks

`timescale 1ns/1ps

module mpt_table_walker (
    input  logic                          clk_i,
    input  logic                          rst_i,

    // Control from the merger
    input  logic                          lookup_start_i,
    input  mpt_pkg::mptw_req_t            lookup_req_i,
    input  logic                          walk_abort_i,
    output logic                          walk_idle_o,
    output logic                          walk_done_o,
    output mpt_pkg::walk_result_t         walk_result_o,

    // Memory read port
    output logic                          mem_req_o,
    output logic [mpt_pkg::SPA_WIDTH-1:0] mem_addr_o,
    input  logic                          mem_ack_i,
    input  mpt_pkg::mpte_u                mem_rdata_i
);

    localparam int unsigned LEVEL_WIDTH = $clog2(mpt_pkg::NUM_LEVELS);
    localparam logic [LEVEL_WIDTH-1:0] LAST_LEVEL = LEVEL_WIDTH'(mpt_pkg::NUM_LEVELS - 1);
    // Zero bits below the index in an entry address
    localparam int unsigned ENTRY_LSB =
        mpt_pkg::SPA_WIDTH - mpt_pkg::PPN_WIDTH - mpt_pkg::LEVEL_IDX_WIDTH;

    typedef enum logic [1:0] {
        W_IDLE,
        W_REQ,
        W_RELEASE
    } walk_state_e;

    walk_state_e                         state_q;
    logic [LEVEL_WIDTH-1:0]              level_q;
    logic [mpt_pkg::SPA_WIDTH-1:0]       spa_q;
    logic [mpt_pkg::PPN_WIDTH-1:0]       ppn_q;
    logic                                abort_q;
    logic                                last_q;
    logic                                done_q;
    mpt_pkg::walk_result_t               result_q;

    logic [mpt_pkg::LEVEL_IDX_WIDTH-1:0] level_idx;
    logic                                entry_last;
    mpt_pkg::walk_result_t               entry_result;

    //////////////////////////////////////////////////
    // Entry address
    //////////////////////////////////////////////////

    // Level 0 takes the top index bits, level 1 the next ones
    assign level_idx = (level_q == '0) ?
        spa_q[mpt_pkg::SPA_WIDTH-1 -: mpt_pkg::LEVEL_IDX_WIDTH] :
        spa_q[mpt_pkg::SPA_WIDTH-mpt_pkg::LEVEL_IDX_WIDTH-1 -: mpt_pkg::LEVEL_IDX_WIDTH];

    assign mem_addr_o = {ppn_q, level_idx, {ENTRY_LSB{1'b0}}};
    assign mem_req_o  = (state_q == W_REQ);

    //////////////////////////////////////////////////
    // Entry decode
    //////////////////////////////////////////////////

    // Leaf bit picks the view, reserved bits checked in that view only
    always_comb begin
        entry_last                = 1'b1;
        entry_result.perm         = '0;
        entry_result.format_error = mpt_pkg::NO_ERROR;
        if (!mem_rdata_i.ptr.valid) begin
            entry_result.format_error = mpt_pkg::ENTRY_NOT_VALID;
        end else if (mem_rdata_i.ptr.leaf) begin
            // Leaf at level 0 is a superpage
            if (mem_rdata_i.leaf.reserved != '0) begin
                entry_result.format_error = mpt_pkg::RESERVED_SET;
            end else begin
                entry_result.perm = mem_rdata_i.leaf.perm;
            end
        end else if (mem_rdata_i.ptr.reserved != '0) begin
            entry_result.format_error = mpt_pkg::RESERVED_SET;
        end else if (level_q == LAST_LEVEL) begin
            entry_result.format_error = mpt_pkg::LEAF_MISSING;
        end else begin
            // Valid pointer, descend
            entry_last = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Walk FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= W_IDLE;
            level_q <= '0;
            abort_q <= 1'b0;
            last_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            // Abort is kept until the open exchange is over
            if (walk_abort_i) begin
                abort_q <= 1'b1;
            end
            case (state_q)
                W_IDLE: begin
                    if (lookup_start_i) begin
                        state_q <= W_REQ;
                        level_q <= '0;
                        abort_q <= 1'b0;
                    end
                end
                W_REQ: begin
                    if (mem_ack_i) begin
                        state_q <= W_RELEASE;
                        last_q  <= entry_last;
                    end
                end
                W_RELEASE: begin
                    // Wait for ack low before the next read
                    if (!mem_ack_i) begin
                        if (abort_q || walk_abort_i) begin
                            state_q <= W_IDLE;
                        end else if (last_q) begin
                            state_q <= W_IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= W_REQ;
                            level_q <= level_q + 1'b1;
                        end
                    end
                end
                default: state_q <= W_IDLE;
            endcase
        end
    end

    // Request fields and decoded entry
    always_ff @(posedge clk_i) begin
        if (state_q == W_IDLE && lookup_start_i) begin
            spa_q <= lookup_req_i.spa;
            ppn_q <= lookup_req_i.mmpt.ppn;
        end else if (state_q == W_REQ && mem_ack_i) begin
            result_q <= entry_result;
            ppn_q    <= mem_rdata_i.ptr.ppn;
        end
    end

    assign walk_idle_o   = (state_q == W_IDLE);
    assign walk_done_o   = done_q;
    assign walk_result_o = result_q;

endmodule : mpt_table_walker

/* mpt_result_merge.sv */
// Request handshake and result selection between PLB and walker
// Permission check and PLB refill after a clean walk

`timescale 1ns/1ps

module mpt_result_merge (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Four-phase request port
    input  logic                  req_i,
    input  mpt_pkg::mptw_req_t    req_data_i,
    output logic                  ack_o,
    output mpt_pkg::mptw_rsp_t    rsp_o,

    // Lookup issue
    output logic                  lookup_start_o,
    output mpt_pkg::mptw_req_t    lookup_req_o,
    input  logic                  plb_hit_i,
    input  mpt_pkg::mpt_perm_t    plb_perm_i,

    // Walker side
    output logic                  walk_abort_o,
    input  logic                  walk_idle_i,
    input  logic                  walk_done_i,
    input  mpt_pkg::walk_result_t walk_result_i,

    // PLB refill
    output logic                  plb_fill_valid_o,
    output mpt_pkg::plb_fill_t    plb_fill_o
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_START,
        M_LOOKUP,
        M_ABORT,
        M_WALK,
        M_ACK
    } merge_state_e;

    merge_state_e          state_q;
    mpt_pkg::mptw_req_t    req_q;
    mpt_pkg::walk_result_t res_q;
    logic                  fill_q;

    // Fault only for a well-formed table
    function automatic mpt_pkg::mptw_rsp_t check_access(
        mpt_pkg::walk_result_t res,
        mpt_pkg::mpt_access_e  access
    );
        mpt_pkg::mptw_rsp_t rsp;
        logic               allowed;
        case (access)
            mpt_pkg::READ:    allowed = res.perm.r;
            mpt_pkg::WRITE:   allowed = res.perm.w;
            mpt_pkg::EXECUTE: allowed = res.perm.x;
            default:          allowed = 1'b0;
        endcase
        rsp.format_error = res.format_error;
        rsp.access_fault = (res.format_error == mpt_pkg::NO_ERROR) && !allowed;
        return rsp;
    endfunction

    //////////////////////////////////////////////////
    // Merge FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= M_IDLE;
            fill_q  <= 1'b0;
        end else begin
            fill_q <= 1'b0;
            case (state_q)
                // Wait for a straggling aborted walk
                M_IDLE:   if (req_i && walk_idle_i) state_q <= M_START;
                M_START:  state_q <= M_LOOKUP;
                M_LOOKUP: state_q <= plb_hit_i ? M_ABORT : M_WALK;
                M_ABORT:  state_q <= M_ACK;
                M_WALK: begin
                    if (walk_done_i) begin
                        state_q <= M_ACK;
                        // Format errors never reach the PLB
                        fill_q  <= (walk_result_i.format_error == mpt_pkg::NO_ERROR);
                    end
                end
                // Hold until the requester lets go
                M_ACK:    if (!req_i) state_q <= M_IDLE;
                default:  state_q <= M_IDLE;
            endcase
        end
    end

    // Latched request and selected result
    always_ff @(posedge clk_i) begin
        if (state_q == M_IDLE && req_i && walk_idle_i) begin
            req_q <= req_data_i;
        end
        if (state_q == M_LOOKUP && plb_hit_i) begin
            res_q.perm         <= plb_perm_i;
            res_q.format_error <= mpt_pkg::NO_ERROR;
        end else if (state_q == M_WALK && walk_done_i) begin
            res_q <= walk_result_i;
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    // Same request to the PLB and the walker
    assign lookup_start_o = (state_q == M_START);
    assign lookup_req_o   = req_q;

    // One-cycle abort pulse on a hit
    assign walk_abort_o = (state_q == M_ABORT);

    assign ack_o = (state_q == M_ACK);
    assign rsp_o = check_access(res_q, req_q.access_type);

    assign plb_fill_valid_o = fill_q;
    assign plb_fill_o.sdid  = req_q.mmpt.sdid;
    assign plb_fill_o.vpn   = req_q.spa[mpt_pkg::SPA_WIDTH-1:mpt_pkg::PAGE_OFFSET_WIDTH];
    assign plb_fill_o.perm  = res_q.perm;

endmodule : mpt_result_merge

/* mptw_top.sv */
// Memory protection table walker top level
// PLB, two-level walker and result merger

`timescale 1ns/1ps

module mptw_top #(
    parameter int unsigned PLB_ENTRIES = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          flush_i,

    // Request port
    input  logic                          req_i,
    input  mpt_pkg::mptw_req_t            req_data_i,
    output logic                          ack_o,
    output mpt_pkg::mptw_rsp_t            rsp_o,

    // Memory port
    output logic                          mem_req_o,
    output logic [mpt_pkg::SPA_WIDTH-1:0] mem_addr_o,
    input  logic                          mem_ack_i,
    input  mpt_pkg::mpte_u                mem_rdata_i
);

    //////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////

    logic                  lookup_start;
    mpt_pkg::mptw_req_t    lookup_req;
    logic                  plb_hit;
    mpt_pkg::mpt_perm_t    plb_perm;
    logic                  walk_abort;
    logic                  walk_idle;
    logic                  walk_done;
    mpt_pkg::walk_result_t walk_result;
    logic                  plb_fill_valid;
    mpt_pkg::plb_fill_t    plb_fill;

    // Permission cache
    plb_cache #(
        .PLB_ENTRIES    ( PLB_ENTRIES    )
    ) plb_cache_u (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .flush_i        ( flush_i        ),
        .lookup_start_i ( lookup_start   ),
        .lookup_req_i   ( lookup_req     ),
        .plb_hit_o      ( plb_hit        ),
        .plb_perm_o     ( plb_perm       ),
        .fill_valid_i   ( plb_fill_valid ),
        .fill_i         ( plb_fill       )
    );

    // Table walk in parallel with the lookup
    mpt_table_walker walker_u (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .lookup_start_i ( lookup_start   ),
        .lookup_req_i   ( lookup_req     ),
        .walk_abort_i   ( walk_abort     ),
        .walk_idle_o    ( walk_idle      ),
        .walk_done_o    ( walk_done      ),
        .walk_result_o  ( walk_result    ),
        .mem_req_o      ( mem_req_o      ),
        .mem_addr_o     ( mem_addr_o     ),
        .mem_ack_i      ( mem_ack_i      ),
        .mem_rdata_i    ( mem_rdata_i    )
    );

    // Handshake, result choice and refill
    mpt_result_merge merge_u (
        .clk_i            ( clk_i          ),
        .rst_i            ( rst_i          ),
        .req_i            ( req_i          ),
        .req_data_i       ( req_data_i     ),
        .ack_o            ( ack_o          ),
        .rsp_o            ( rsp_o          ),
        .lookup_start_o   ( lookup_start   ),
        .lookup_req_o     ( lookup_req     ),
        .plb_hit_i        ( plb_hit        ),
        .plb_perm_i       ( plb_perm       ),
        .walk_abort_o     ( walk_abort     ),
        .walk_idle_i      ( walk_idle      ),
        .walk_done_i      ( walk_done      ),
        .walk_result_i    ( walk_result    ),
        .plb_fill_valid_o ( plb_fill_valid ),
        .plb_fill_o       ( plb_fill       )
    );

endmodule : mptw_top

/* mptw_assertions.sv */
// Handshake assertions for the request and memory ports
// Bound into mptw_top

`timescale 1ns/1ps

module mptw_assertions (
    input logic                          clk_i,
    input logic                          rst_i,
    input logic                          req_i,
    input logic                          ack_o,
    input logic                          mem_req_o,
    input logic                          mem_ack_i,
    input logic [mpt_pkg::SPA_WIDTH-1:0] mem_addr_o
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Ack only answers a live request
    ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_o) |-> req_i)
        else begin
            $error("ack_o rose while req_i was low");
            fail_count++;
        end

    // Memory request held until acked
    mem_req_holds: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_o && !mem_ack_i |=> mem_req_o)
        else begin
            $error("mem_req_o dropped before mem_ack_i");
            fail_count++;
        end

    mem_addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o))
        else begin
            $error("mem_addr_o changed during a memory request");
            fail_count++;
        end

    // From the second reset cycle on
    quiet_in_reset: assert property (@(posedge clk_i)
        rst_i && $past(rst_i) |-> !ack_o && !mem_req_o)
        else begin
            $error("ack_o or mem_req_o high during reset");
            fail_count++;
        end

endmodule : mptw_assertions

bind mptw_top mptw_assertions assertions_u (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .req_i      ( req_i      ),
    .ack_o      ( ack_o      ),
    .mem_req_o  ( mem_req_o  ),
    .mem_ack_i  ( mem_ack_i  ),
    .mem_addr_o ( mem_addr_o )
);

/* tb_mptw_top.sv */
// Testbench for the memory protection table walker
// Clock, reset, memory model, stimulus table and result checks

`timescale 1ns/1ps

module tb_mptw_top;

    localparam int unsigned TIMEOUT_CYCLES = 200;
    // Level-0 read already issued before the PLB answers still completes
    localparam logic [1:0]  HIT_READS      = 2'd1;
    localparam logic [19:0] ROOT_PPN       = 20'h00010;
    localparam logic [19:0] L1_PPN         = 20'h00020;
    localparam logic [19:0] L2_PPN         = 20'h00030;
    localparam logic [7:0]  DOM_A          = 8'h01;
    localparam logic [7:0]  DOM_B          = 8'h02;

    // One stimulus row with its expected outcome
    typedef struct packed {
        mpt_pkg::mptw_req_t req;
        logic               flush;
        mpt_pkg::mptw_rsp_t exp_rsp;
        logic [1:0]         exp_reads;
    } row_t;

    logic                          clk_i;
    logic                          rst_i;
    logic                          flush_i;
    logic                          req_i;
    mpt_pkg::mptw_req_t            req_data_i;
    logic                          ack_o;
    mpt_pkg::mptw_rsp_t            rsp_o;
    logic                          mem_req_o;
    logic [mpt_pkg::SPA_WIDTH-1:0] mem_addr_o;
    logic                          mem_ack_i;
    mpt_pkg::mpte_u                mem_rdata_i;

    integer      seed;
    int          mem_reads;
    int          delay_cnt;
    logic        mem_busy;
    logic [31:0] mem_tbl [logic [31:0]];
    row_t        rows [$];

    mptw_top #(
        .PLB_ENTRIES ( 4 )
    ) dut (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .flush_i     ( flush_i     ),
        .req_i       ( req_i       ),
        .req_data_i  ( req_data_i  ),
        .ack_o       ( ack_o       ),
        .rsp_o       ( rsp_o       ),
        .mem_req_o   ( mem_req_o   ),
        .mem_addr_o  ( mem_addr_o  ),
        .mem_ack_i   ( mem_ack_i   ),
        .mem_rdata_i ( mem_rdata_i )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Entry encoding
    //////////////////////////////////////////////////

    // valid, leaf=0, reserved, page number
    function automatic logic [31:0] ptr_entry(input logic [19:0] ppn, input logic [9:0] rsvd);
        return {1'b1, 1'b0, rsvd, ppn};
    endfunction

    // valid, leaf=1, r w x, reserved
    function automatic logic [31:0] leaf_entry(input logic [2:0] rwx, input logic [26:0] rsvd);
        return {1'b1, 1'b1, rwx, rsvd};
    endfunction

    function automatic logic [31:0] entry_addr(input logic [19:0] ppn, input logic [9:0] idx);
        return {ppn, idx, 2'b00};
    endfunction

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////

    // Four-phase responder, random delay before each ack
    always @(posedge clk_i) begin
        if (rst_i) begin
            mem_ack_i <= 1'b0;
            mem_busy  <= 1'b0;
            delay_cnt <= 0;
            mem_reads <= 0;
        end else if (mem_ack_i) begin
            if (!mem_req_o) begin
                mem_ack_i <= 1'b0;
            end
        end else if (mem_req_o) begin
            if (!mem_busy) begin
                mem_busy  <= 1'b1;
                delay_cnt <= $unsigned($random(seed)) % 4;
            end else if (delay_cnt != 0) begin
                delay_cnt <= delay_cnt - 1;
            end else begin
                // Unmapped words read as zero, an invalid entry
                mem_ack_i   <= 1'b1;
                mem_rdata_i <= mem_tbl.exists(mem_addr_o) ? mem_tbl[mem_addr_o] : 32'h0;
                mem_reads   <= mem_reads + 1;
                mem_busy    <= 1'b0;
            end
        end
    end

    task automatic load_tables();
        // Level 0 at the root page
        mem_tbl[entry_addr(ROOT_PPN, 10'd1)] = ptr_entry(L1_PPN, 10'h000);
        mem_tbl[entry_addr(ROOT_PPN, 10'd2)] = leaf_entry(3'b100, 27'h0);
        mem_tbl[entry_addr(ROOT_PPN, 10'd4)] = ptr_entry(L1_PPN, 10'h001);
        // Level 1, index 5 wrongly points further down
        mem_tbl[entry_addr(L1_PPN, 10'd1)] = leaf_entry(3'b101, 27'h0);
        mem_tbl[entry_addr(L1_PPN, 10'd2)] = leaf_entry(3'b010, 27'h0);
        mem_tbl[entry_addr(L1_PPN, 10'd4)] = leaf_entry(3'b111, 27'h100);
        mem_tbl[entry_addr(L1_PPN, 10'd5)] = ptr_entry(L2_PPN, 10'h000);
        mem_tbl[entry_addr(L1_PPN, 10'd6)] = leaf_entry(3'b110, 27'h0);
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic add_row(
        input logic [9:0]                  idx0,
        input logic [9:0]                  idx1,
        input logic [7:0]                  sdid,
        input mpt_pkg::mpt_access_e        access,
        input logic                        flush,
        input logic                        fault,
        input mpt_pkg::page_format_fault_e fmt,
        input logic [1:0]                  reads
    );
        row_t row;
        // Random page offset, the PLB tag ignores it
        row.req.spa              = {idx0, idx1, 12'($random(seed))};
        row.req.mmpt.sdid        = sdid;
        row.req.mmpt.ppn         = ROOT_PPN;
        row.req.access_type      = access;
        row.flush                = flush;
        row.exp_rsp.access_fault = fault;
        row.exp_rsp.format_error = fmt;
        row.exp_reads            = reads;
        rows.push_back(row);
    endtask

    task automatic build_rows();
        // Level-1 leaves, one access type each
        add_row(1, 1, DOM_A, mpt_pkg::READ,    0, 0, mpt_pkg::NO_ERROR, 2);
        add_row(1, 2, DOM_A, mpt_pkg::WRITE,   0, 0, mpt_pkg::NO_ERROR, 2);
        add_row(1, 6, DOM_A, mpt_pkg::EXECUTE, 0, 1, mpt_pkg::NO_ERROR, 2);
        add_row(1, 2, DOM_A, mpt_pkg::READ,    1, 1, mpt_pkg::NO_ERROR, 2);
        add_row(1, 1, DOM_A, mpt_pkg::WRITE,   0, 1, mpt_pkg::NO_ERROR, 2);
        // Superpage walk, then hits
        add_row(2, 7, DOM_A, mpt_pkg::READ,    0, 0, mpt_pkg::NO_ERROR, 1);
        add_row(2, 7, DOM_A, mpt_pkg::WRITE,   0, 1, mpt_pkg::NO_ERROR, HIT_READS);
        add_row(1, 1, DOM_A, mpt_pkg::READ,    0, 0, mpt_pkg::NO_ERROR, HIT_READS);
        // Malformed tables
        add_row(3, 0, DOM_A, mpt_pkg::READ,    0, 0, mpt_pkg::ENTRY_NOT_VALID, 1);
        add_row(1, 3, DOM_A, mpt_pkg::READ,    0, 0, mpt_pkg::ENTRY_NOT_VALID, 2);
        add_row(4, 1, DOM_A, mpt_pkg::WRITE,   0, 0, mpt_pkg::RESERVED_SET, 1);
        add_row(1, 4, DOM_A, mpt_pkg::EXECUTE, 0, 0, mpt_pkg::RESERVED_SET, 2);
        add_row(1, 5, DOM_A, mpt_pkg::READ,    0, 0, mpt_pkg::LEAF_MISSING, 2);
        add_row(1, 4, DOM_A, mpt_pkg::EXECUTE, 0, 0, mpt_pkg::RESERVED_SET, 2);
        // Other domain walks, first domain still hits
        add_row(1, 1, DOM_B, mpt_pkg::READ,    0, 0, mpt_pkg::NO_ERROR, 2);
        add_row(1, 1, DOM_A, mpt_pkg::EXECUTE, 0, 0, mpt_pkg::NO_ERROR, HIT_READS);
        // Flushed PLB walks again
        add_row(1, 1, DOM_A, mpt_pkg::READ,    1, 0, mpt_pkg::NO_ERROR, 2);
        add_row(4, 1, DOM_A, mpt_pkg::WRITE,   1, 0, mpt_pkg::RESERVED_SET, 1);
        add_row(2, 7, DOM_A, mpt_pkg::READ,    0, 0, mpt_pkg::NO_ERROR, 1);
    endtask

    //////////////////////////////////////////////////
    // Checks and waits
    //////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s took more than %0d cycles", $time, what, TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Sampled on the falling edge, away from the DUT updates
    task automatic wait_for_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (ack_o !== level) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                report_timeout({what, " waiting for ack_o"});
            end
            cycles++;
            @(negedge clk_i);
        end
    endtask

    // An aborted walk may still be finishing its read
    task automatic wait_mem_quiet(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (mem_req_o || mem_ack_i) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                report_timeout({what, " waiting for an idle memory port"});
            end
            cycles++;
            @(negedge clk_i);
        end
    endtask

    task automatic apply_row(input row_t row, input int idx);
        int                 reads_before;
        int                 hold;
        mpt_pkg::mptw_rsp_t first_rsp;
        string              tag;
        tag = $sformatf("row %0d", idx);
        if (row.flush) begin
            @(posedge clk_i);
            flush_i <= 1'b1;
            @(posedge clk_i);
            flush_i <= 1'b0;
        end
        reads_before = mem_reads;
        @(posedge clk_i);
        req_i      <= 1'b1;
        req_data_i <= row.req;
        wait_for_ack(1'b1, tag);
        first_rsp = rsp_o;
        check_value(rsp_o, row.exp_rsp, {tag, " response"});
        // Slow release, response must hold
        hold = $unsigned($random(seed)) % 5;
        repeat (hold) begin
            @(negedge clk_i);
            check_value(ack_o, 1'b1, {tag, " ack_o while req_i held"});
            check_value(rsp_o, first_rsp, {tag, " rsp_o while req_i held"});
        end
        @(posedge clk_i);
        req_i <= 1'b0;
        wait_for_ack(1'b0, tag);
        wait_mem_quiet(tag);
        check_value(mem_reads - reads_before, row.exp_reads, {tag, " memory reads"});
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        seed        = 32'h691a_fd84;
        rst_i       = 1'b1;
        flush_i     = 1'b0;
        req_i       = 1'b0;
        req_data_i  = '0;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        load_tables();
        build_rows();
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i], i);
        end
        if (dut.assertions_u.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule : tb_mptw_top

/* compile.f */
mpt_pkg.sv
plb_cache.sv
mpt_table_walker.sv
mpt_result_merge.sv
mptw_top.sv
mptw_assertions.sv
tb_mptw_top.sv

/* Bender.yml */
# Memory protection table walker

package:
  name: mptw

dependencies: {}

sources:
  # Design, package first
  - files:
      - mpt_pkg.sv
      - plb_cache.sv
      - mpt_table_walker.sv
      - mpt_result_merge.sv
      - mptw_top.sv

  # Verification
  - target: test
    files:
      - mptw_assertions.sv
      - tb_mptw_top.sv
